//--- src/dds_pkg.sv
package dds_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////////////////////////
   localparam int PHASE_WIDTH    = 32;   // phase accumulator
   localparam int SAMPLE_WIDTH   = 12;   // carrier word
   localparam int SCOPE_WIDTH    = 8;    // offset-binary scope byte
   localparam int LUT_ADDR_WIDTH = 6;    // quarter table address
   localparam int LUT_DEPTH      = 64;   // quarter table length
   localparam int LFSR_WIDTH     = 5;

   //////////////////////////////////////////////////////////////////////
   // constants
   //////////////////////////////////////////////////////////////////////
   localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 5'd1;
   localparam int LFSR_TICK_DEFAULT = 25_000_000;   // one step per second at 25 MHz
   localparam logic signed [SAMPLE_WIDTH-1:0] SQUARE_LEVEL = 12'sd2047;
   localparam logic [SAMPLE_WIDTH-1:0] LFSR_MARK_LEVEL = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};
   localparam string SINE_TABLE_FILE = "src/sine_quarter.hex";

   // wave select codes
   localparam logic [1:0] WAVE_SIN    = 2'd0;
   localparam logic [1:0] WAVE_COS    = 2'd1;
   localparam logic [1:0] WAVE_SQUARE = 2'd2;
   localparam logic [1:0] WAVE_SAW    = 2'd3;

   // modulation select codes
   localparam logic [1:0] MOD_ASK  = 2'd0;
   localparam logic [1:0] MOD_BPSK = 2'd1;
   localparam logic [1:0] MOD_LFSR = 2'd2;
   localparam logic [1:0] MOD_NONE = 2'd3;

   // one sample, seen as a number or as the fields the scope plot uses
   typedef union packed {
      logic signed [SAMPLE_WIDTH-1:0] value;
      struct packed {
         logic                                sign;
         logic [SCOPE_WIDTH-2:0]              coarse;   // lands in the scope byte
         logic [SAMPLE_WIDTH-SCOPE_WIDTH-1:0] fine;     // dropped on the scope
      } fields;
   } sample_word_u;

endpackage

//--- src/phase_accumulator.sv
`timescale 1ns/10ps

module phase_accumulator
   import dds_pkg::*;
(
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  logic [PHASE_WIDTH-1:0] phase_inc,
   output logic [PHASE_WIDTH-1:0] phase
);

   //////////////////////////////////////////////////////////////////////
   // tuning word sets the output frequency
   // f_out = phase_inc * 25 MHz / 2^32
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase <= '0;
      end
      else
      begin
         phase <= phase + phase_inc;   // wraps at a full turn
      end
   end

endmodule

//--- src/wave_shaper.sv
`timescale 1ns/10ps

module wave_shaper
   import dds_pkg::*;
(
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  logic [PHASE_WIDTH-1:0] phase,
   output sample_word_u           sin_wave,
   output sample_word_u           cos_wave,
   output sample_word_u           square_wave,
   output sample_word_u           saw_wave
);

   logic [SAMPLE_WIDTH-1:0] sine_table [LUT_DEPTH];   // first quarter, magnitudes only
   logic [PHASE_WIDTH-1:0]  cos_phase;
   sample_word_u            sin_next;
   sample_word_u            cos_next;
   sample_word_u            square_next;
   sample_word_u            saw_next;

   initial
   begin
      $readmemh(SINE_TABLE_FILE, sine_table);
   end

   // quadrant 1 and 3 run the table backwards, 2 and 3 are negated
   function automatic sample_word_u quarter_lookup(input logic [PHASE_WIDTH-1:0] p);
      logic [1:0]                quadrant;
      logic [LUT_ADDR_WIDTH-1:0] addr;
      logic [SAMPLE_WIDTH-1:0]   magnitude;
      sample_word_u              word;
      quadrant  = p[PHASE_WIDTH-1 -: 2];
      addr      = p[PHASE_WIDTH-3 -: LUT_ADDR_WIDTH];
      if (quadrant[0])
         addr = ~addr;                   // mirrored index
      magnitude  = sine_table[addr];
      word.value = quadrant[1] ? -magnitude : magnitude;
      return word;
   endfunction

   assign cos_phase = phase + {2'b01, {(PHASE_WIDTH-2){1'b0}}};   // quarter turn ahead

   always_comb
   begin
      sin_next          = quarter_lookup(phase);
      cos_next          = quarter_lookup(cos_phase);
      square_next.value = phase[PHASE_WIDTH-1] ? -SQUARE_LEVEL : SQUARE_LEVEL;
      saw_next.value    = {~phase[PHASE_WIDTH-1], phase[PHASE_WIDTH-2 -: SAMPLE_WIDTH-1]};
   end

   //////////////////////////////////////////////////////////////////////
   // one register stage for all four carriers
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sin_wave    <= '0;
         cos_wave    <= '0;
         square_wave <= '0;
         saw_wave    <= '0;
      end
      else
      begin
         sin_wave    <= sin_next;
         cos_wave    <= cos_next;
         square_wave <= square_next;
         saw_wave    <= saw_next;   // ramp from -2048 up to +2047
      end
   end

endmodule

//--- src/lfsr_bit_source.sv
`timescale 1ns/10ps

module lfsr_bit_source
   import dds_pkg::*;
#(
   parameter int tick_divide = LFSR_TICK_DEFAULT
)
(
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   output logic [LFSR_WIDTH-1:0] lfsr_state
);

   logic [$clog2(tick_divide+1)-1:0] tick_count;
   logic                             tick;

   // enable pulse on the last count of each period
   assign tick = (tick_count == $bits(tick_count)'(tick_divide - 1));

   //////////////////////////////////////////////////////////////////////
   // divider and x^5 + x^3 + 1 shift register, 31 states
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_count <= '0;
         lfsr_state <= LFSR_SEED;
      end
      else if (tick)
      begin
         tick_count <= '0;
         lfsr_state <= {lfsr_state[LFSR_WIDTH-2:0], lfsr_state[4] ^ lfsr_state[2]};
      end
      else
      begin
         tick_count <= tick_count + 1'b1;
      end
   end

endmodule

//--- src/carrier_modulator.sv
`timescale 1ns/10ps

module carrier_modulator
   import dds_pkg::*;
(
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  sample_word_u           sin_wave,
   input  sample_word_u           cos_wave,
   input  sample_word_u           square_wave,
   input  sample_word_u           saw_wave,
   input  logic [1:0]             wave_select,
   input  logic [1:0]             modulation_select,
   input  logic [LFSR_WIDTH-1:0]  lfsr_state,
   output sample_word_u           carrier_sample,
   output sample_word_u           modulated_sample,
   output logic [SCOPE_WIDTH-1:0] carrier_scope,
   output logic [SCOPE_WIDTH-1:0] modulated_scope
);

   sample_word_u selected;
   sample_word_u modulated;

   always_comb
   begin
      case (wave_select)
         WAVE_SIN:    selected = sin_wave;
         WAVE_COS:    selected = cos_wave;
         WAVE_SQUARE: selected = square_wave;
         default:     selected = saw_wave;
      endcase
      case (modulation_select)
         MOD_ASK:  modulated = lfsr_state[0] ? selected : '0;   // on-off keying
         MOD_BPSK: modulated.value = lfsr_state[0] ? -selected.value : selected.value;
         MOD_LFSR: modulated = (|lfsr_state) ? LFSR_MARK_LEVEL : '0;
         default:  modulated = selected;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // output words and their offset-binary scope bytes
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         carrier_sample   <= '0;
         modulated_sample <= '0;
         carrier_scope    <= '0;
         modulated_scope  <= '0;
      end
      else
      begin
         carrier_sample   <= selected;
         modulated_sample <= modulated;
         carrier_scope    <= {~selected.fields.sign, selected.fields.coarse};
         modulated_scope  <= {~modulated.fields.sign, modulated.fields.coarse};
      end
   end

endmodule

//--- src/dds_modulator_top.sv
`timescale 1ns/10ps

module dds_modulator_top
   import dds_pkg::*;
#(
   parameter int lfsr_tick_divide = LFSR_TICK_DEFAULT
)
(
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  logic [PHASE_WIDTH-1:0] phase_inc,
   input  logic [1:0]             wave_select,
   input  logic [1:0]             modulation_select,
   output sample_word_u           carrier_sample,
   output sample_word_u           modulated_sample,
   output logic [SCOPE_WIDTH-1:0] carrier_scope,
   output logic [SCOPE_WIDTH-1:0] modulated_scope,
   output logic [LFSR_WIDTH-1:0]  lfsr_state
);

   logic [PHASE_WIDTH-1:0] phase;
   sample_word_u           sin_wave;
   sample_word_u           cos_wave;
   sample_word_u           square_wave;
   sample_word_u           saw_wave;

   //////////////////////////////////////////////////////////////////////
   // phase -> carriers -> modulated words, two register stages
   //////////////////////////////////////////////////////////////////////
   phase_accumulator phase_acc0 (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .phase          (phase)
   );

   wave_shaper shaper0 (.*);   // all ports share names with this level

   lfsr_bit_source #(.tick_divide(lfsr_tick_divide)) lfsr0 (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_state     (lfsr_state)   // also the data bit for the modulator
   );

   carrier_modulator modulator0 (.*);

endmodule

//--- bench/dds_assertions.sv
`timescale 1ns/10ps

module dds_assertions
   import dds_pkg::*;
(
   input logic                   CLK_25MHZ,
   input logic                   reset_from_key,
   input logic [1:0]             modulation_select,
   input logic [LFSR_WIDTH-1:0]  lfsr_state,
   input sample_word_u           carrier_sample,
   input sample_word_u           modulated_sample,
   input logic [SCOPE_WIDTH-1:0] carrier_scope,
   input logic [SCOPE_WIDTH-1:0] modulated_scope
);

   // scope byte is the top of the word shifted to offset binary
   carrier_scope_match : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !$past(reset_from_key) |->
         carrier_scope == SCOPE_WIDTH'((int'(carrier_sample.value) + 2048) >> 4))
      else $error("carrier_scope does not match carrier_sample");

   modulated_scope_match : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !$past(reset_from_key) |->
         modulated_scope == SCOPE_WIDTH'((int'(modulated_sample.value) + 2048) >> 4))
      else $error("modulated_scope does not match modulated_sample");

   // on-off keying gives silence or the carrier itself
   ask_zero_or_carrier : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !$past(reset_from_key) && $past(modulation_select) == MOD_ASK |->
         modulated_sample.value == '0 || modulated_sample == carrier_sample)
      else $error("ASK output is neither zero nor the carrier");

   lfsr_never_zero : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_state != '0 |=> lfsr_state != '0)
      else $error("lfsr_state stepped into the all-zero lock-up state");

endmodule

bind carrier_modulator dds_assertions assertions0 (.*);

//--- bench/dds_tb.sv
`timescale 1ns/10ps

module dds_tb
   import dds_pkg::*;
();

   localparam int CLK_PERIOD  = 40;
   localparam int TICK        = 16;   // lfsr step period in cycles
   localparam int TEST_CYCLES = 10 + 160 + 520 + 33 * TICK + 400 + 200 + 200;

   logic                    CLK_25MHZ;
   logic                    reset_from_key;
   logic [PHASE_WIDTH-1:0]  phase_inc;
   logic [1:0]              wave_select;
   logic [1:0]              modulation_select;
   sample_word_u            carrier_sample;
   sample_word_u            modulated_sample;
   logic [SCOPE_WIDTH-1:0]  carrier_scope;
   logic [SCOPE_WIDTH-1:0]  modulated_scope;
   logic [LFSR_WIDTH-1:0]   lfsr_state;

   logic [SAMPLE_WIDTH-1:0] sine_ref [64];
   logic [PHASE_WIDTH-1:0]  m_phase;
   int                      m_count;
   logic [LFSR_WIDTH-1:0]   m_lfsr;
   logic                    m_in_reset;
   sample_word_u            m_wave [4];   // model carrier regs, by select code
   sample_word_u            exp_carrier;
   sample_word_u            exp_modulated;
   int                      errors;
   int                      checks;
   int                      seed = 32'h0b6768ba;

   dds_modulator_top #(.lfsr_tick_divide(TICK)) dut0 (.*);

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #(CLK_PERIOD / 2) CLK_25MHZ = ~CLK_25MHZ;
   end

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////
   function automatic int sine_of(input logic [PHASE_WIDTH-1:0] p);
      int idx;
      int mag;
      idx = p[29:24];
      if (p[30])
         idx = 63 - idx;   // falling part of each half turn
      mag = sine_ref[idx];
      return p[31] ? -mag : mag;
   endfunction

   function automatic logic [SCOPE_WIDTH-1:0] scope_of(input sample_word_u w);
      return SCOPE_WIDTH'((int'(w.value) + 2048) >> 4);   // offset binary, top 8 bits
   endfunction

   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         m_in_reset    = 1'b1;
         m_phase       = '0;
         m_count       = 0;
         m_lfsr        = 5'd1;
         exp_carrier   = '0;
         exp_modulated = '0;
         foreach (m_wave[i])
            m_wave[i] = '0;
      end
      else
      begin
         m_in_reset  = 1'b0;
         exp_carrier = m_wave[wave_select];
         case (modulation_select)
            MOD_ASK:  exp_modulated.value = m_lfsr[0] ? exp_carrier.value : 12'sd0;
            MOD_BPSK: exp_modulated.value = SAMPLE_WIDTH'(m_lfsr[0] ?
                         -int'(exp_carrier.value) : int'(exp_carrier.value));
            MOD_LFSR: exp_modulated.value = (m_lfsr != 0) ? 12'h800 : 12'h000;
            default:  exp_modulated = exp_carrier;
         endcase
         m_wave[WAVE_SIN].value    = SAMPLE_WIDTH'(sine_of(m_phase));
         m_wave[WAVE_COS].value    = SAMPLE_WIDTH'(sine_of(m_phase + 32'h4000_0000));
         m_wave[WAVE_SQUARE].value = m_phase[31] ? -12'sd2047 : 12'sd2047;
         m_wave[WAVE_SAW].value    = SAMPLE_WIDTH'(int'(m_phase[31:20]) - 2048);
         m_phase = m_phase + phase_inc;
         if (m_count == TICK - 1)
         begin
            m_count = 0;
            m_lfsr  = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
         end
         else
            m_count = m_count + 1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////////////////////////
   task automatic check_sample(input sample_word_u got, input sample_word_u exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t: %s is %0d, expected %0d", $time, what, got.value, exp.value);
      end
   endtask

   task automatic check_scope(input logic [SCOPE_WIDTH-1:0] got,
                              input logic [SCOPE_WIDTH-1:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_lfsr(input logic [LFSR_WIDTH-1:0] got,
                             input logic [LFSR_WIDTH-1:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_outputs();
      check_sample(carrier_sample, exp_carrier, "carrier_sample");
      check_sample(modulated_sample, exp_modulated, "modulated_sample");
      check_scope(carrier_scope, m_in_reset ? 8'h00 : scope_of(exp_carrier), "carrier_scope");
      check_scope(modulated_scope, m_in_reset ? 8'h00 : scope_of(exp_modulated),
                  "modulated_scope");
      check_lfsr(lfsr_state, m_lfsr, "lfsr_state");
   endtask

   task automatic run_cycles(input int n);
      repeat (n)
      begin
         @(negedge CLK_25MHZ);
         check_outputs();
      end
   endtask

   task automatic report(input string name, input int errors_before);
      $display("test %-12s done, %0d errors", name, errors - errors_before);
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////
   task automatic test_reset();
      int e0;
      e0 = errors;
      reset_from_key = 1'b1;
      repeat (10) @(negedge CLK_25MHZ);
      check_outputs();
      check_lfsr(lfsr_state, 5'd1, "lfsr_state after reset");
      reset_from_key = 1'b0;
      report("reset", e0);
   endtask

   task automatic test_square_saw();
      int e0;
      e0 = errors;
      modulation_select = MOD_NONE;
      for (int i = 0; i < 8; i++)
      begin
         phase_inc   = $random(seed);
         wave_select = i[0] ? WAVE_SAW : WAVE_SQUARE;
         run_cycles(20);
      end
      report("square_saw", e0);
   endtask

   task automatic test_sine_cosine();
      int e0;
      e0 = errors;
      phase_inc   = 32'h0100_0000;   // one table step per cycle
      wave_select = WAVE_SIN;
      run_cycles(260);
      wave_select = WAVE_COS;
      run_cycles(260);
      report("sine_cosine", e0);
   endtask

   task automatic test_lfsr_sequence();
      logic [LFSR_WIDTH-1:0] seen [$];
      int                    e0;
      int                    since;
      e0    = errors;
      since = 0;
      seen.push_back(lfsr_state);
      while (seen.size() < 32 && since <= TICK)
      begin
         run_cycles(1);
         since++;
         if (lfsr_state != seen[$])
         begin
            if (seen.size() > 1 && since != TICK)
            begin
               errors++;
               $display("ERR %0t: lfsr step after %0d cycles, expected %0d", $time, since, TICK);
            end
            seen.push_back(lfsr_state);
            since = 0;
         end
      end
      if (seen.size() < 32)
      begin
         errors++;
         $display("lfsr_state stopped stepping during the sequence test");
      end
      else
      begin
         for (int i = 1; i < 31; i++)
            for (int j = 0; j < i; j++)
               if (seen[i] == seen[j])
               begin
                  errors++;
                  $display("ERR %0t: lfsr state %b repeats after %0d steps", $time, seen[i], i - j);
               end
         if (seen[31] !== seen[0])
         begin
            errors++;
            $display("ERR %0t: lfsr period is not 31 steps", $time);
         end
      end
      report("lfsr_sequence", e0);
   endtask

   task automatic test_modulation();
      int e0;
      e0          = errors;
      phase_inc   = 32'h0123_4567;
      wave_select = WAVE_SIN;
      for (int m = 0; m < 4; m++)
      begin
         modulation_select = 2'(m);
         run_cycles(100);
      end
      report("modulation", e0);
   endtask

   task automatic test_scope_bytes();
      int e0;
      e0                = errors;
      modulation_select = MOD_BPSK;
      for (int i = 0; i < 4; i++)
      begin
         phase_inc   = $random(seed);
         wave_select = 2'(i);
         run_cycles(50);
      end
      report("scope_bytes", e0);
   endtask

   initial
   begin
      reset_from_key    = 1'b1;
      phase_inc         = '0;
      wave_select       = WAVE_SIN;
      modulation_select = MOD_NONE;
      errors            = 0;
      checks            = 0;
      $readmemh("src/sine_quarter.hex", sine_ref);
      test_reset();
      test_square_saw();
      test_sine_cosine();
      test_lfsr_sequence();
      test_modulation();
      test_scope_bytes();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   // watchdog
   initial
   begin
      #(TEST_CYCLES * CLK_PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      $display("TEST FAIL");
      $finish;
   end

endmodule

//--- bender.yml
package:
  name: dds_modulator

# the sine table src/sine_quarter.hex is read by $readmemh at elaboration
sources:
  - src/dds_pkg.sv
  - src/phase_accumulator.sv
  - src/wave_shaper.sv
  - src/lfsr_bit_source.sv
  - src/carrier_modulator.sv
  - src/dds_modulator_top.sv
  - target: simulation
    files:
      - bench/dds_assertions.sv
      - bench/dds_tb.sv

//--- build.f
src/dds_pkg.sv
src/phase_accumulator.sv
src/wave_shaper.sv
src/lfsr_bit_source.sv
src/carrier_modulator.sv
src/dds_modulator_top.sv
bench/dds_assertions.sv
bench/dds_tb.sv

//--- src/sine_quarter.hex
// quarter-wave sine magnitude, one 12-bit hex word per table index 0..63
019
04B
07E
0B0
0E2
113
145
177
1A8
1D9
20A
23A
26A
29A
2C9
2F8
327
354
382
3AF
3DB
407
432
45C
486
4AF
4D7
4FF
526
54C
571
596
5B9
5DC
5FD
61E
63E
65D
67B
698
6B4
6CF
6E9
701
719
730
745
759
76D
77F
790
79F
7AE
7BB
7C8
7D3
7DC
7E5
7EC
7F3
7F7
7FB
7FE
7FF
